/* rtl/rv_isa_pkg.sv */
package rv_isa_pkg;

    typedef enum logic [ 6 : 0 ] {
        OP_OP     = 7'b0110011,                                 // R-type arithmetic
        OP_IMM    = 7'b0010011,                                 // I-type arithmetic
        OP_LOAD   = 7'b0000011,                                 // lw
        OP_STORE  = 7'b0100011,                                 // sw
        OP_BRANCH = 7'b1100011,                                 // beq, bne
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111
    } opcode_e;

    typedef enum logic [ 3 : 0 ] {
        ALU_ADD = 4'b0000,
        ALU_SUB = 4'b0001,
        ALU_AND = 4'b0010,
        ALU_OR  = 4'b0011,
        ALU_SLT = 4'b0101                                       // Signed compare
    } alu_ctrl_e;

    typedef enum logic [ 1 : 0 ] {
        ALUOP_MEM    = 2'b00,                                   // Address calc, always add
        ALUOP_BRANCH = 2'b01,                                   // Compare, always subtract
        ALUOP_ARITH  = 2'b10                                    // Look at funct fields
    } alu_op_e;

    typedef enum logic [ 1 : 0 ] { IMM_I, IMM_S, IMM_B, IMM_J } imm_src_e;

    localparam logic [ 2 : 0 ] F3_BEQ     = 3'b000;
    localparam logic [ 2 : 0 ] F3_BNE     = 3'b001;
    localparam logic [ 2 : 0 ] F3_ADD_SUB = 3'b000;            // add, sub, addi
    localparam logic [ 2 : 0 ] F3_SLT     = 3'b010;
    localparam logic [ 2 : 0 ] F3_OR      = 3'b110;
    localparam logic [ 2 : 0 ] F3_AND     = 3'b111;

endpackage

/* rtl/rv_core_pkg.sv */
package rv_core_pkg;

    localparam int IMEM_DEPTH_DEF = 64;                         // Program words

    typedef enum logic [ 1 : 0 ] {
        RES_ALU = 2'b00,                                        // ALU result to rd
        RES_MEM = 2'b01,                                        // Load data to rd
        RES_PC4 = 2'b10                                         // Link address to rd
    } result_src_e;

    // Main decoder share of the control word
    typedef struct packed {
        logic        pc_src;                                    // Branch or jump taken
        result_src_e result_src;
        logic        mem_write;
        logic        alu_src;                                   // Immediate as operand B
        logic        reg_write;
        logic        jalr_pc_src;                               // Target from ALU
    } dec_ctrl_t;

    typedef struct packed {
        logic                  pc_src;
        result_src_e           result_src;
        logic                  mem_write;
        logic                  alu_src;
        logic                  reg_write;
        logic                  jalr_pc_src;
        rv_isa_pkg::alu_ctrl_e alu_ctrl;
    } ctrl_t;

    typedef struct packed {
        logic [ 31 : 0 ] addr;                                  // Byte address
        logic [ 31 : 0 ] wdata;
        logic            we;                                    // Store strobe
    } dmem_req_t;

endpackage

/* rtl/instr_mem.sv */
`timescale 1ns/1ps

module instr_mem #(
    parameter int DEPTH = 64
) (
    input  logic                         clk_i,
    input  logic                         we_i,                  // Program load strobe
    input  logic [ $clog2(DEPTH) - 1 : 0 ] waddr_i,             // Load word index
    input  logic [ 31 : 0 ]              wdata_i,
    input  logic [ $clog2(DEPTH) - 1 : 0 ] addr_i,              // Fetch word index
    output logic [ 31 : 0 ]              rd_o                   // Fetched instruction
);

    logic [ 31 : 0 ] mem [ DEPTH ];                             // Program store

    always_ff @(posedge clk_i) begin
        if (we_i && (int'(waddr_i) < DEPTH)) begin             // Drop loads past the end
            mem[waddr_i] <= wdata_i;
        end
    end

    // All zeros is illegal and decodes to nothing
    assign rd_o = (int'(addr_i) < DEPTH) ? mem[addr_i] : 32'h0000_0000;

endmodule

/* rtl/main_decoder.sv */
`timescale 1ns/1ps

module main_decoder (
    input  logic [ 6 : 0 ]        op_i,                         // Opcode field
    input  logic [ 2 : 0 ]        funct3_i,                     // Branch condition
    input  logic                  eq_i,                         // Operands equal
    output rv_core_pkg::dec_ctrl_t ctrl_o,
    output rv_isa_pkg::alu_op_e   alu_op_o,
    output rv_isa_pkg::imm_src_e  imm_src_o
);

    import rv_isa_pkg::*;
    import rv_core_pkg::*;

    logic branch;                                               // Conditional branch
    logic jump;                                                 // jal or jalr
    logic take;                                                 // Condition holds

    // beq on equal, bne on not equal, other conditions never taken
    assign take = (funct3_i == F3_BEQ) ? eq_i  :
                  (funct3_i == F3_BNE) ? ~eq_i : 1'b0;

    always_comb begin
        ctrl_o    = '0;                                         // No writes by default
        alu_op_o  = ALUOP_MEM;
        imm_src_o = IMM_I;
        branch    = 1'b0;
        jump      = 1'b0;
        case (op_i)
            OP_OP: begin
                ctrl_o.reg_write = 1'b1;
                alu_op_o         = ALUOP_ARITH;
            end
            OP_IMM: begin
                ctrl_o.reg_write = 1'b1;
                ctrl_o.alu_src   = 1'b1;
                alu_op_o         = ALUOP_ARITH;
            end
            OP_LOAD: begin
                ctrl_o.reg_write  = 1'b1;
                ctrl_o.alu_src    = 1'b1;                       // rs1 + offset
                ctrl_o.result_src = RES_MEM;
            end
            OP_STORE: begin
                ctrl_o.mem_write = 1'b1;
                ctrl_o.alu_src   = 1'b1;
                imm_src_o        = IMM_S;
            end
            OP_BRANCH: begin
                branch    = 1'b1;
                alu_op_o  = ALUOP_BRANCH;
                imm_src_o = IMM_B;
            end
            OP_JAL: begin
                ctrl_o.reg_write  = 1'b1;
                ctrl_o.result_src = RES_PC4;                    // Link
                imm_src_o         = IMM_J;
                jump              = 1'b1;
            end
            OP_JALR: begin
                ctrl_o.reg_write   = 1'b1;
                ctrl_o.alu_src     = 1'b1;                      // rs1 + offset as target
                ctrl_o.result_src  = RES_PC4;
                ctrl_o.jalr_pc_src = 1'b1;
                jump               = 1'b1;
            end
            default: ;                                          // Illegal, stays idle
        endcase
        ctrl_o.pc_src = jump | (branch & take);
    end

endmodule

/* rtl/alu_decoder.sv */
`timescale 1ns/1ps

module alu_decoder (
    input  logic                  op5_i,                        // Set for R-type
    input  logic [ 2 : 0 ]        funct3_i,
    input  logic                  funct7_5_i,                   // Sub select on R-type
    input  rv_isa_pkg::alu_op_e   alu_op_i,
    output rv_isa_pkg::alu_ctrl_e alu_ctrl_o
);

    import rv_isa_pkg::*;

    always_comb begin
        alu_ctrl_o = ALU_ADD;                                   // Loads, stores, jalr
        if (alu_op_i == ALUOP_BRANCH) begin
            alu_ctrl_o = ALU_SUB;                               // Compare
        end else if (alu_op_i == ALUOP_ARITH) begin
            case (funct3_i)
                F3_ADD_SUB: begin
                    if (op5_i && funct7_5_i) begin              // addi ignores bit 30
                        alu_ctrl_o = ALU_SUB;
                    end else begin
                        alu_ctrl_o = ALU_ADD;
                    end
                end
                F3_SLT:  alu_ctrl_o = ALU_SLT;
                F3_OR:   alu_ctrl_o = ALU_OR;
                F3_AND:  alu_ctrl_o = ALU_AND;
                default: alu_ctrl_o = ALU_ADD;                  // Unsupported funct3
            endcase
        end
    end

endmodule

/* rtl/sign_extend.sv */
`timescale 1ns/1ps

module sign_extend (
    input  logic [ 31 : 7 ]       instr31_7_i,                  // Instruction minus opcode
    input  rv_isa_pkg::imm_src_e  imm_src_i,                    // Format select
    output logic [ 31 : 0 ]       imm_ext_o
);

    import rv_isa_pkg::*;

    always_comb begin
        case (imm_src_i)
            IMM_I: imm_ext_o = {{20{instr31_7_i[31]}}, instr31_7_i[31:20]};
            IMM_S: imm_ext_o = {{20{instr31_7_i[31]}}, instr31_7_i[31:25],
                                instr31_7_i[11:7]};
            IMM_B: imm_ext_o = {{20{instr31_7_i[31]}}, instr31_7_i[7],
                                instr31_7_i[30:25], instr31_7_i[11:8], 1'b0};
            IMM_J: imm_ext_o = {{12{instr31_7_i[31]}}, instr31_7_i[19:12],
                                instr31_7_i[20], instr31_7_i[30:21], 1'b0};
            default: imm_ext_o = 32'h0000_0000;
        endcase
    end

endmodule

/* rtl/control_top.sv */
`timescale 1ns/1ps

module control_top #(
    parameter int IMEM_DEPTH = rv_core_pkg::IMEM_DEPTH_DEF
) (
    input  logic                              clk_i,
    input  logic                              prog_we_i,       // Program load strobe
    input  logic [ $clog2(IMEM_DEPTH) - 1 : 0 ] prog_addr_i,   // Load word index
    input  logic [ 31 : 0 ]                   prog_data_i,
    input  logic [ 31 : 0 ]                   pc_i,            // Program counter
    input  logic                              eq_i,            // Equal flag from ALU
    output rv_core_pkg::ctrl_t                ctrl_o,          // Datapath controls
    output logic [ 31 : 0 ]                   imm_op_o,        // Extended immediate
    output logic [ 4 : 0 ]                    rs1_o,           // Operand A register
    output logic [ 4 : 0 ]                    rs2_o,           // Operand B register
    output logic [ 4 : 0 ]                    rd_o             // Destination register
);

    import rv_isa_pkg::*;
    import rv_core_pkg::*;

    localparam int AW = $clog2(IMEM_DEPTH);                     // Word index width

    logic [ 31 : 0 ] instr;                                     // Current instruction
    dec_ctrl_t       dec;                                       // Main decoder controls
    alu_op_e         alu_op;
    imm_src_e        imm_src;
    alu_ctrl_e       alu_ctrl;

    assign rs1_o = instr[19:15];
    assign rs2_o = instr[24:20];
    assign rd_o  = instr[11:7];

    instr_mem #(.DEPTH(IMEM_DEPTH)) instr_mem (
        .clk_i   (clk_i),
        .we_i    (prog_we_i),
        .waddr_i (prog_addr_i),
        .wdata_i (prog_data_i),
        .addr_i  (pc_i[2 +: AW]),                              // Byte PC to word index
        .rd_o    (instr)
    );

    main_decoder main_decoder (
        .op_i      (instr[6:0]),
        .funct3_i  (instr[14:12]),
        .eq_i      (eq_i),
        .ctrl_o    (dec),
        .alu_op_o  (alu_op),
        .imm_src_o (imm_src)
    );

    alu_decoder alu_decoder (
        .op5_i      (instr[5]),
        .funct3_i   (instr[14:12]),
        .funct7_5_i (instr[30]),
        .alu_op_i   (alu_op),
        .alu_ctrl_o (alu_ctrl)
    );

    sign_extend sign_extend (
        .instr31_7_i (instr[31:7]),
        .imm_src_i   (imm_src),
        .imm_ext_o   (imm_op_o)
    );

    assign ctrl_o = '{
        pc_src:      dec.pc_src,
        result_src:  dec.result_src,
        mem_write:   dec.mem_write,
        alu_src:     dec.alu_src,
        reg_write:   dec.reg_write,
        jalr_pc_src: dec.jalr_pc_src,
        alu_ctrl:    alu_ctrl                                   // From ALU decoder
    };

endmodule

/* rtl/reg_file.sv */
`timescale 1ns/1ps

module reg_file (
    input  logic            clk_i,
    input  logic            rst_n_i,
    input  logic            we_i,                               // Already gated by run
    input  logic [ 4 : 0 ]  ra1_i,
    input  logic [ 4 : 0 ]  ra2_i,
    input  logic [ 4 : 0 ]  wa_i,
    input  logic [ 31 : 0 ] wd_i,
    output logic [ 31 : 0 ] rd1_o,
    output logic [ 31 : 0 ] rd2_o
);

    logic [ 31 : 0 ] regs [ 32 ];                               // x0 .. x31

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= 32'h0000_0000;
            end
        end else if (we_i && (wa_i != 5'd0)) begin             // Writes to x0 dropped
            regs[wa_i] <= wd_i;
        end
    end

    assign rd1_o = (ra1_i == 5'd0) ? 32'h0000_0000 : regs[ra1_i];
    assign rd2_o = (ra2_i == 5'd0) ? 32'h0000_0000 : regs[ra2_i];

endmodule

/* rtl/alu.sv */
`timescale 1ns/1ps

module alu (
    input  logic [ 31 : 0 ]       a_i,                          // rs1
    input  logic [ 31 : 0 ]       b_i,                          // rs2 or immediate
    input  rv_isa_pkg::alu_ctrl_e ctrl_i,
    output logic [ 31 : 0 ]       y_o,
    output logic                  eq_o                          // For beq, bne
);

    import rv_isa_pkg::*;

    always_comb begin
        case (ctrl_i)
            ALU_ADD: y_o = a_i + b_i;
            ALU_SUB: y_o = a_i - b_i;
            ALU_AND: y_o = a_i & b_i;
            ALU_OR:  y_o = a_i | b_i;
            ALU_SLT: y_o = {31'd0, $signed(a_i) < $signed(b_i)}; // Two's complement compare
            default: y_o = 32'h0000_0000;
        endcase
    end

    // Direct compare, independent of the selected operation
    assign eq_o = (a_i == b_i);

endmodule

/* rtl/rv_cpu_top.sv */
`timescale 1ns/1ps

module rv_cpu_top #(
    parameter int IMEM_DEPTH = rv_core_pkg::IMEM_DEPTH_DEF
) (
    input  logic                              clk_i,
    input  logic                              rst_n_i,
    input  logic                              prog_we_i,       // Load only in reset
    input  logic [ $clog2(IMEM_DEPTH) - 1 : 0 ] prog_addr_i,
    input  logic [ 31 : 0 ]                   prog_data_i,
    output rv_core_pkg::dmem_req_t            dmem_req_o,      // Load or store request
    input  logic [ 31 : 0 ]                   dmem_rdata_i     // Same-cycle load data
);

    import rv_core_pkg::*;

    logic [ 31 : 0 ] pc;
    logic [ 31 : 0 ] pc_next;
    logic [ 31 : 0 ] pc_plus4;
    logic [ 31 : 0 ] pc_target;                                 // Branch and jal target
    logic            run;                                       // Core executing
    ctrl_t           ctrl;
    logic [ 31 : 0 ] imm_op;
    logic [ 4 : 0 ]  rs1;
    logic [ 4 : 0 ]  rs2;
    logic [ 4 : 0 ]  rd;
    logic [ 31 : 0 ] rd1;
    logic [ 31 : 0 ] rd2;
    logic [ 31 : 0 ] alu_b;
    logic [ 31 : 0 ] alu_y;
    logic            eq;
    logic [ 31 : 0 ] wb_data;                                   // Register writeback

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            run <= 1'b0;
        end else begin
            run <= 1'b1;                                        // First edge after release
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc <= 32'h0000_0000;
        end else if (run) begin
            pc <= pc_next;
        end
    end

    assign pc_plus4  = pc + 32'd4;
    assign pc_target = pc + imm_op;

    always_comb begin
        if (!ctrl.pc_src) begin
            pc_next = pc_plus4;
        end else if (ctrl.jalr_pc_src) begin
            pc_next = {alu_y[31:1], 1'b0};                      // jalr clears bit 0
        end else begin
            pc_next = pc_target;
        end
    end

    control_top #(.IMEM_DEPTH(IMEM_DEPTH)) control_top (
        .clk_i       (clk_i),
        .prog_we_i   (prog_we_i),
        .prog_addr_i (prog_addr_i),
        .prog_data_i (prog_data_i),
        .pc_i        (pc),
        .eq_i        (eq),                                      // Combinational loop back
        .ctrl_o      (ctrl),
        .imm_op_o    (imm_op),
        .rs1_o       (rs1),
        .rs2_o       (rs2),
        .rd_o        (rd)
    );

    reg_file reg_file (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .we_i    (ctrl.reg_write & run),
        .ra1_i   (rs1),
        .ra2_i   (rs2),
        .wa_i    (rd),
        .wd_i    (wb_data),
        .rd1_o   (rd1),
        .rd2_o   (rd2)
    );

    assign alu_b = ctrl.alu_src ? imm_op : rd2;

    alu alu (
        .a_i    (rd1),
        .b_i    (alu_b),
        .ctrl_i (ctrl.alu_ctrl),
        .y_o    (alu_y),
        .eq_o   (eq)
    );

    always_comb begin
        case (ctrl.result_src)
            RES_MEM: wb_data = dmem_rdata_i;
            RES_PC4: wb_data = pc_plus4;                        // Link value
            default: wb_data = alu_y;
        endcase
    end

    assign dmem_req_o = '{
        addr:  alu_y,                                           // rs1 + offset
        wdata: rd2,
        we:    ctrl.mem_write & run                             // Quiet in reset
    };

endmodule

/* test/tb_rv_cpu.sv */
`timescale 1ns/1ps

module tb_rv_cpu;

    import rv_core_pkg::*;

    localparam int IMEM_DEPTH   = 64;
    localparam int AW           = $clog2(IMEM_DEPTH);
    localparam int PROG_LEN     = 46;
    localparam int N_STORES     = 17;
    localparam int DMEM_WORDS   = 64;                           // 256 byte data space
    localparam int RESET_CYCLES = 10;
    localparam int SETTLE       = 8;                            // Quiet cycles in the self-loop
    localparam int TIMEOUT      = PROG_LEN * 4 + 50;
    localparam logic [ 31 : 0 ] STORE_BASE = 32'h0000_0040;     // x10 after instruction 2

    // Hand-assembled program, word index in the left column of each comment
    localparam logic [ 31 : 0 ] PROG [ PROG_LEN ] = '{
        32'h00002083,   //  0 lw   x1, 0(x0)       a operand
        32'h00402103,   //  1 lw   x2, 4(x0)       b operand
        32'h04000513,   //  2 addi x10, x0, 64
        32'h002081B3,   //  3 add  x3, x1, x2
        32'h00352023,   //  4 sw   x3, 0(x10)
        32'h40208233,   //  5 sub  x4, x1, x2
        32'h00452223,   //  6 sw   x4, 4(x10)
        32'h0020F2B3,   //  7 and  x5, x1, x2
        32'h00552423,   //  8 sw   x5, 8(x10)
        32'h0020E333,   //  9 or   x6, x1, x2
        32'h00652623,   // 10 sw   x6, 12(x10)
        32'h0020A3B3,   // 11 slt  x7, x1, x2
        32'h00752823,   // 12 sw   x7, 16(x10)
        32'h00112433,   // 13 slt  x8, x2, x1
        32'h00852A23,   // 14 sw   x8, 20(x10)
        32'hFFB10493,   // 15 addi x9, x2, -5
        32'h00952C23,   // 16 sw   x9, 24(x10)
        32'hFF00F593,   // 17 andi x11, x1, -16
        32'h00B52E23,   // 18 sw   x11, 28(x10)
        32'hF0016613,   // 19 ori  x12, x2, -256
        32'h02C52023,   // 20 sw   x12, 32(x10)
        32'hFFF0A693,   // 21 slti x13, x1, -1
        32'h02D52223,   // 22 sw   x13, 36(x10)
        32'h02252423,   // 23 sw   x2, 40(x10)
        32'h02852703,   // 24 lw   x14, 40(x10)
        32'h02E52623,   // 25 sw   x14, 44(x10)
        32'h00208463,   // 26 beq  x1, x2, +8      not taken
        32'h02252823,   // 27 sw   x2, 48(x10)
        32'h00210463,   // 28 beq  x2, x2, +8      taken
        32'h02152A23,   // 29 sw   x1, 52(x10)     skipped
        32'h00209463,   // 30 bne  x1, x2, +8      taken
        32'h02152C23,   // 31 sw   x1, 56(x10)     skipped
        32'h00109463,   // 32 bne  x1, x1, +8      not taken
        32'h02152E23,   // 33 sw   x1, 60(x10)
        32'h008007EF,   // 34 jal  x15, +8
        32'h04152023,   // 35 sw   x1, 64(x10)     skipped
        32'h04F52223,   // 36 sw   x15, 68(x10)
        32'h0A000813,   // 37 addi x16, x0, 160
        32'h008808E7,   // 38 jalr x17, 8(x16)     to word 42
        32'h04152423,   // 39 sw   x1, 72(x10)     skipped
        32'h04152623,   // 40 sw   x1, 76(x10)     skipped
        32'h04152823,   // 41 sw   x1, 80(x10)     skipped
        32'h05152A23,   // 42 sw   x17, 84(x10)
        32'h00508013,   // 43 addi x0, x1, 5
        32'h04052C23,   // 44 sw   x0, 88(x10)
        32'h0000006F    // 45 jal  x0, 0
    };

    logic              clk;
    logic              rst_n;
    logic              prog_we;
    logic [ AW - 1 : 0 ] prog_addr;
    logic [ 31 : 0 ]   prog_data;
    dmem_req_t         dmem_req;
    logic [ 31 : 0 ]   dmem_rdata;

    logic [ 31 : 0 ]   dmem [ DMEM_WORDS ];                     // Data memory model
    logic [ 31 : 0 ]   a_op;                                    // Negative operand
    logic [ 31 : 0 ]   b_op;                                    // Positive operand
    string             exp_name [ N_STORES ];
    logic [ 31 : 0 ]   exp_addr [ N_STORES ];
    logic [ 31 : 0 ]   exp_data [ N_STORES ];
    int                n_exp = 0;                               // Table fill index
    int                n_seen = 0;                              // Stores observed
    int                cycle_cnt = 0;                           // Cycles since release

    rv_cpu_top #(.IMEM_DEPTH(IMEM_DEPTH)) UUT (
        .clk_i        (clk),
        .rst_n_i      (rst_n),
        .prog_we_i    (prog_we),
        .prog_addr_i  (prog_addr),
        .prog_data_i  (prog_data),
        .dmem_req_o   (dmem_req),
        .dmem_rdata_i (dmem_rdata)
    );

    assign dmem_rdata = dmem[dmem_req.addr[7:2]];               // Same-cycle load data

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [ 31 : 0 ] xorshift32(input logic [ 31 : 0 ] s);
        logic [ 31 : 0 ] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Operands at words 0 and 1, elsewhere a marker of the byte address
    function automatic logic [ 31 : 0 ] fill_word(input int i);
        if (i == 0) return a_op;
        if (i == 1) return b_op;
        return 32'hC0DE_0000 | 32'(i << 2);
    endfunction

    task automatic add_expect(input string name, input logic [ 31 : 0 ] offs,
                              input logic [ 31 : 0 ] data);
        exp_name[n_exp] = name;
        exp_addr[n_exp] = STORE_BASE + offs;                    // Base plus offset
        exp_data[n_exp] = data;
        n_exp++;
    endtask

    task automatic report_failure;
        $display("Test FAILED");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    task automatic check_store(input dmem_req_t req);
        if (n_seen >= N_STORES) begin
            $display("Unexpected store of %h to %h after the last expected one",
                     req.wdata, req.addr);
            report_failure();
        end else begin
            assert (req.addr == exp_addr[n_seen]) else begin
                $display("[FAIL] %s address expected %h actual %h",
                         exp_name[n_seen], exp_addr[n_seen], req.addr);
                report_failure();
            end
            assert (req.wdata == exp_data[n_seen]) else begin
                $display("[FAIL] %s data expected %h actual %h",
                         exp_name[n_seen], exp_data[n_seen], req.wdata);
                report_failure();
            end
        end
    endtask

    // Memory fill in reset, store capture and checks once running
    always @(posedge clk) begin
        if (!rst_n) begin
            assert (!dmem_req.we) else begin
                $display("Store strobe went high while the core was held in reset");
                report_failure();
            end
            for (int i = 0; i < DMEM_WORDS; i++) begin
                dmem[i] <= fill_word(i);
            end
        end else begin
            cycle_cnt <= cycle_cnt + 1;
            if (dmem_req.we) begin
                check_store(dmem_req);
                dmem[dmem_req.addr[7:2]] <= dmem_req.wdata;
                n_seen <= n_seen + 1;
            end
        end
    end

    initial begin
        logic [ 31 : 0 ] rng;
        rst_n     = 1'b0;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = 32'h0000_0000;
        rng  = xorshift32(32'd53);
        a_op = rng | 32'h8000_0000;                             // Force sign bit
        rng  = xorshift32(rng);
        b_op = rng & 32'h7FFF_FFFF;
        add_expect("add",           32'd0,  a_op + b_op);
        add_expect("sub",           32'd4,  a_op - b_op);
        add_expect("and",           32'd8,  a_op & b_op);
        add_expect("or",            32'd12, a_op | b_op);
        add_expect("slt_neg_pos",   32'd16, {31'd0, $signed(a_op) < $signed(b_op)});
        add_expect("slt_pos_neg",   32'd20, {31'd0, $signed(b_op) < $signed(a_op)});
        add_expect("addi_neg_imm",  32'd24, b_op - 32'd5);
        add_expect("andi_neg_imm",  32'd28, a_op & 32'hFFFF_FFF0);
        add_expect("ori_neg_imm",   32'd32, b_op | 32'hFFFF_FF00);
        add_expect("slti_neg_imm",  32'd36, {31'd0, $signed(a_op) < -32'sd1});
        add_expect("sw_base_off",   32'd40, b_op);
        add_expect("lw_round_trip", 32'd44, b_op);
        add_expect("beq_not_taken", 32'd48, b_op);
        add_expect("bne_not_taken", 32'd60, a_op);
        add_expect("jal_link",      32'd68, 32'(34 * 4 + 4));   // Word 34 plus 4
        add_expect("jalr_target",   32'd84, 32'(38 * 4 + 4));
        add_expect("x0_discard",    32'd88, 32'h0000_0000);
        @(negedge clk);                                         // A store sits at word 0 first
        prog_we   = 1'b1;
        prog_addr = '0;
        prog_data = PROG[4];
        for (int k = 0; k < PROG_LEN; k++) begin                // Load while in reset
            @(negedge clk);
            prog_we   = 1'b1;
            prog_addr = AW'(k);
            prog_data = PROG[k];
        end
        @(negedge clk);
        prog_we = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        while (n_seen < N_STORES && cycle_cnt < TIMEOUT) begin
            @(negedge clk);
        end
        if (n_seen < N_STORES) begin
            $display("Timeout after %0d cycles with only %0d of %0d expected stores seen",
                     cycle_cnt, n_seen, N_STORES);
            report_failure();
        end else begin
            repeat (SETTLE) @(negedge clk);                     // Extra stores caught above
            $display("Test OK");
            $finish;
        end
    end

endmodule

/* sources.f */
rtl/rv_isa_pkg.sv
rtl/rv_core_pkg.sv
rtl/instr_mem.sv
rtl/main_decoder.sv
rtl/alu_decoder.sv
rtl/sign_extend.sv
rtl/control_top.sv
rtl/reg_file.sv
rtl/alu.sv
rtl/rv_cpu_top.sv
test/tb_rv_cpu.sv

/* run.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f sources.f --top-module tb_rv_cpu -o tb_rv_cpu_sim \
    && ./obj_dir/tb_rv_cpu_sim | tee /dev/stderr | grep -qx "Test OK" \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }
